// File: include/icache_params.svh
// width and depth macros for the instruction cache address map and data path.
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ##################################################
// address fields
// ##################################################

// fetch address is a halfword address, bits 18:1 of the byte address.
`define ICACHE_FETCH_AW 18

// word address used on the memory port, bits 18:2 of the byte address.
`define ICACHE_WORD_AW 17

// index into the data banks and tag store, word address bits 10:2.
`define ICACHE_INDEX_W 9

// tag kept per index, word address bits 18:11.
`define ICACHE_TAG_W 8

// ##################################################
// storage and data
// ##################################################

`define ICACHE_DEPTH 512
`define ICACHE_DATA_W 32

`endif

// File: verilog/icache_pkg.sv
// packed struct types shared by the instruction cache and its memory and core ports.
package icache_pkg;

    // ##################################################
    // storage payloads
    // ##################################################

    // one halfword of a memory word, held in either data bank.
    typedef logic [15:0] half_t;

    // one tag store entry. valid is cleared on reset and set on refill.
    typedef struct packed {
        logic       valid;
        logic [7:0] tag;
    } tag_entry_t;

    // ##################################################
    // memory port
    // ##################################################

    // the address is held while valid is high until ready is seen.
    typedef struct packed {
        logic        valid;
        logic [16:0] addr;   // word address, byte bits 18:2.
    } mem_req_t;

    // ready is a single cycle pulse with rdata valid in that cycle.
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } mem_rsp_t;

    // ##################################################
    // core port
    // ##################################################

    // instr is valid in any cycle where stall is low.
    typedef struct packed {
        logic        stall;
        logic [31:0] instr;  // may straddle two memory words.
    } fetch_rsp_t;

endpackage

// File: verilog/icache_data_ram.sv
// single port halfword bank with clocked write and combinational read.
module icache_data_ram #(
    parameter type payload_t = logic [15:0]
) (
    input  logic       clk_i,
    input  logic       we_i,
    input  logic [8:0] addr_i,
    input  payload_t   wdata_i,
    output payload_t   rdata_o
);

    localparam int ram_depth = 512;

    // ##################################################
    // storage
    // ##################################################

    // entries are only trusted once the tag store marks them valid.
    payload_t mem_q [ram_depth];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;  // refill writes at the steered index.
        end
    end

    // ##################################################
    // read
    // ##################################################

    // a hit has to be answered in the same cycle as the address.
    assign rdata_o = mem_q[addr_i];

endmodule

// File: verilog/icache_tag_store.sv
// tag array and valid vector with one write port and two read ports.
module icache_tag_store (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic                   we_i,
    input  logic [8:0]             waddr_i,
    input  logic [7:0]             wtag_i,

    input  logic [8:0]             raddr0_i,
    input  logic [8:0]             raddr1_i,
    output icache_pkg::tag_entry_t entry0_o,
    output icache_pkg::tag_entry_t entry1_o
);

    localparam int tag_depth = 512;

    logic [7:0]           tag_q [tag_depth];
    logic [tag_depth-1:0] valid_q;

    // ##################################################
    // write port
    // ##################################################

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_q[waddr_i] <= wtag_i;
        end
    end

    // the valid vector is what makes an empty cache miss after reset.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[waddr_i] <= 1'b1;
        end
    end

    // ##################################################
    // read ports
    // ##################################################

    // port 0 looks up the bank 0 word and port 1 the bank 1 word.
    always_comb begin
        entry0_o.valid = valid_q[raddr0_i];
        entry0_o.tag   = tag_q[raddr0_i];
        entry1_o.valid = valid_q[raddr1_i];
        entry1_o.tag   = tag_q[raddr1_i];
    end

endmodule

// File: verilog/icache_fetch_ctrl.sv
// lookup and refill FSM with halfword alignment and data bank addressing.
module icache_fetch_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // core side.
    input  logic [17:0]            fetch_addr_i,
    output icache_pkg::fetch_rsp_t fetch_rsp_o,

    // instruction memory side.
    output icache_pkg::mem_req_t   mem_req_o,
    input  icache_pkg::mem_rsp_t   mem_rsp_i,

    // tag store lookups.
    input  icache_pkg::tag_entry_t entry0_i,
    input  icache_pkg::tag_entry_t entry1_i,
    output logic [8:0]             tag_raddr0_o,
    output logic [8:0]             tag_raddr1_o,

    // data banks.
    input  icache_pkg::half_t      half0_i,
    input  icache_pkg::half_t      half1_i,
    output logic [8:0]             bank0_addr_o,
    output logic [8:0]             bank1_addr_o,
    output logic                   we_o
);

    typedef enum logic [1:0] {
        st_lookup  = 2'd0,
        st_refill0 = 2'd1,
        st_refill1 = 2'd2
    } state_t;

    state_t state_q;
    state_t state_d;

    logic        half_sel;
    logic [7:0]  fetch_tag;
    logic [8:0]  idx0;
    logic [8:0]  idx1;
    logic        hit0;
    logic        hit1;
    logic [16:0] refill_addr;

    // ##################################################
    // address split and tag compare
    // ##################################################

    // fetch_addr_i[0] is byte address bit 1 and picks the upper halfword.
    assign half_sel  = fetch_addr_i[0];
    assign fetch_tag = fetch_addr_i[17:10];

    // bank 1 always reads word W. bank 0 reads W+1 when the fetch is misaligned.
    assign idx1 = fetch_addr_i[9:1];
    assign idx0 = idx1 + {8'd0, half_sel};

    assign tag_raddr0_o = idx0;
    assign tag_raddr1_o = idx1;

    assign hit0 = entry0_i.valid && (entry0_i.tag == fetch_tag);
    assign hit1 = entry1_i.valid && (entry1_i.tag == fetch_tag);

    // the word for bank 0 goes out first since it is refilled first.
    assign refill_addr = (state_q == st_refill1) ? {fetch_tag, idx1} : {fetch_tag, idx0};

    // ##################################################
    // state register and next state
    // ##################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= st_lookup;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_lookup: begin
                if (!hit0) begin
                    state_d = st_refill0;
                end else if (!hit1) begin
                    state_d = st_refill1;
                end
            end
            st_refill0: begin
                if (mem_rsp_i.ready) begin
                    state_d = st_lookup;  // bank 1 word is checked again on return.
                end
            end
            st_refill1: begin
                if (mem_rsp_i.ready) begin
                    state_d = st_lookup;
                end
            end
            default: begin
                state_d = st_lookup;
            end
        endcase
    end

    // ##################################################
    // memory request and bank steering
    // ##################################################

    always_comb begin
        mem_req_o.addr = refill_addr;
        if (state_q == st_lookup) begin
            mem_req_o.valid = 1'b0;
            bank0_addr_o    = idx0;
            bank1_addr_o    = idx1;
            we_o            = 1'b0;
        end else begin
            mem_req_o.valid = 1'b1;
            bank0_addr_o    = refill_addr[8:0];  // both halves land at one index.
            bank1_addr_o    = refill_addr[8:0];
            we_o            = mem_rsp_i.ready;
        end
    end

    // ##################################################
    // fetch response
    // ##################################################

    // a misaligned fetch puts the low half of W+1 above the high half of W.
    always_comb begin
        fetch_rsp_o.stall = (state_q != st_lookup) || !(hit0 && hit1);
        if (half_sel) begin
            fetch_rsp_o.instr = {half0_i, half1_i};
        end else begin
            fetch_rsp_o.instr = {half1_i, half0_i};
        end
    end

endmodule

// File: verilog/icache_top.sv
// instruction cache top level with controller, two halfword banks and tag store.
`include "icache_params.svh"

module icache_top (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic [`ICACHE_FETCH_AW-1:0]   fetch_addr_i,
    output icache_pkg::fetch_rsp_t        fetch_rsp_o,
    output icache_pkg::mem_req_t          mem_req_o,
    input  icache_pkg::mem_rsp_t          mem_rsp_i
);

    logic [`ICACHE_INDEX_W-1:0] bank0_addr;
    logic [`ICACHE_INDEX_W-1:0] bank1_addr;
    logic [`ICACHE_INDEX_W-1:0] tag_raddr0;
    logic [`ICACHE_INDEX_W-1:0] tag_raddr1;
    logic                       we;
    icache_pkg::tag_entry_t     entry0;
    icache_pkg::tag_entry_t     entry1;
    icache_pkg::half_t          half0;
    icache_pkg::half_t          half1;

    icache_fetch_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fetch_addr_i (fetch_addr_i),
        .fetch_rsp_o  (fetch_rsp_o),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .entry0_i     (entry0),
        .entry1_i     (entry1),
        .tag_raddr0_o (tag_raddr0),
        .tag_raddr1_o (tag_raddr1),
        .half0_i      (half0),
        .half1_i      (half1),
        .bank0_addr_o (bank0_addr),
        .bank1_addr_o (bank1_addr),
        .we_o         (we)
    );

    // bank 0 keeps the low halfword of every memory word.
    icache_data_ram #(.payload_t(icache_pkg::half_t)) u_bank0 (
        .clk_i   (clk_i),
        .we_i    (we),
        .addr_i  (bank0_addr),
        .wdata_i (mem_rsp_i.rdata[`ICACHE_DATA_W/2-1:0]),
        .rdata_o (half0)
    );

    icache_data_ram #(.payload_t(icache_pkg::half_t)) u_bank1 (
        .clk_i   (clk_i),
        .we_i    (we),
        .addr_i  (bank1_addr),
        .wdata_i (mem_rsp_i.rdata[`ICACHE_DATA_W-1:`ICACHE_DATA_W/2]),
        .rdata_o (half1)
    );

    // the refill index and tag come straight from the held request address.
    icache_tag_store u_tags (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .we_i     (we),
        .waddr_i  (mem_req_o.addr[`ICACHE_INDEX_W-1:0]),
        .wtag_i   (mem_req_o.addr[`ICACHE_WORD_AW-1 -: `ICACHE_TAG_W]),
        .raddr0_i (tag_raddr0),
        .raddr1_i (tag_raddr1),
        .entry0_o (entry0),
        .entry1_o (entry1)
    );

endmodule

// File: testbench/icache_chk.sv
// concurrent assertions on the instruction memory port and the fetch response.
module icache_chk (
    input logic                   clk_i,
    input logic                   rst_i,
    input icache_pkg::fetch_rsp_t fetch_rsp_i,
    input icache_pkg::mem_req_t   mem_req_i,
    input icache_pkg::mem_rsp_t   mem_rsp_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // ##################################################
    // memory port
    // ##################################################

    // once reset has been seen for a full cycle the FSM sits in lookup.
    req_idle_in_reset: assert property (@(posedge clk_i)
        (rst_i && $past(rst_i)) |-> !mem_req_i.valid)
        else $error("memory request raised while reset is high");

    req_addr_held: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_i.valid && !mem_rsp_i.ready) |=> (mem_req_i.valid && $stable(mem_req_i.addr)))
        else $error("memory request dropped or changed before ready");

    // ##################################################
    // fetch response
    // ##################################################

    // a request only follows a stalled lookup and keeps the core stalled.
    stall_during_refill: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_i.valid |-> (fetch_rsp_i.stall && $past(fetch_rsp_i.stall)))
        else $error("fetch not stalled while a refill is outstanding");

endmodule

bind icache_top icache_chk u_chk (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fetch_rsp_i (fetch_rsp_o),
    .mem_req_i   (mem_req_o),
    .mem_rsp_i   (mem_rsp_i)
);

// File: testbench/icache_tb.sv
// testbench with clock, reset, instruction memory model, directed fetch tests and summary.
`include "icache_params.svh"

module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 50;
    localparam int drive_delay = 5;
    // 200 random fetches plus a few directed ones, each at most two refills of up
    // to eight cycles, stay far below this limit.
    localparam int cycle_limit = 20000;

    logic                        clk_i;
    logic                        rst_i;
    logic [`ICACHE_FETCH_AW-1:0] fetch_addr_i;
    icache_pkg::fetch_rsp_t      fetch_rsp_o;
    icache_pkg::mem_req_t        mem_req_o;
    icache_pkg::mem_rsp_t        mem_rsp_i;

    integer      seed = 32'h2880;
    int          cycle_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          error_cnt = 0;
    bit          reset_req_seen = 1'b0;
    logic [16:0] req_q [$];  // word addresses served during the current fetch.

    // expected contents of the tag store.
    bit          shadow_valid [`ICACHE_DEPTH];
    logic [7:0]  shadow_tag [`ICACHE_DEPTH];

    icache_top UUT (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fetch_addr_i (fetch_addr_i),
        .fetch_rsp_o  (fetch_rsp_o),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #half_period clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("ERROR: the run hit the limit of %0d cycles before all tests ended.",
                     cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // ##################################################
    // instruction memory model
    // ##################################################

    function automatic logic [31:0] mem_word(input logic [16:0] addr);
        logic [31:0] prod;
        prod = {15'd0, addr} * 32'h9E37_79B1;
        return prod ^ 32'hA5C3_5A3C;
    endfunction

    initial begin : mem_model
        int wait_left;
        bit busy;
        wait_left = 0;
        busy      = 1'b0;
        mem_rsp_i = '0;
        forever begin
            @(posedge clk_i);
            #drive_delay;
            mem_rsp_i.ready = 1'b0;
            if (rst_i && mem_req_o.valid) begin
                reset_req_seen = 1'b1;
            end
            if (!rst_i && mem_req_o.valid) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = $unsigned($random(seed)) % 6;  // latency 0 to 5 cycles.
                end
                if (wait_left == 0) begin
                    mem_rsp_i.ready = 1'b1;
                    mem_rsp_i.rdata = mem_word(mem_req_o.addr);
                    req_q.push_back(mem_req_o.addr);
                    busy = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // ##################################################
    // prediction and checking
    // ##################################################

    function automatic bit shadow_hit(input logic [16:0] word);
        return shadow_valid[word[8:0]] && (shadow_tag[word[8:0]] == word[16:9]);
    endfunction

    function automatic logic [17:0] make_addr(input logic [7:0] tag, input logic [8:0] idx,
                                              input logic half);
        return {tag, idx, half};
    endfunction

    task automatic fetch_check(input string name, input logic [17:0] addr, inout int errs);
        logic [16:0] word_lo;
        logic [16:0] word_hi;
        logic [16:0] exp_req [$];
        logic [31:0] lo_data;
        logic [31:0] hi_data;
        logic [31:0] exp_instr;
        bit          first_stall;
        word_lo = addr[17:1];
        word_hi = word_lo + {16'd0, addr[0]};
        // the bank 0 word is refilled first, then the bank 1 word if still missing.
        if (!shadow_hit(word_hi)) begin
            exp_req.push_back(word_hi);
            shadow_valid[word_hi[8:0]] = 1'b1;
            shadow_tag[word_hi[8:0]]   = word_hi[16:9];
        end
        if (!shadow_hit(word_lo)) begin
            exp_req.push_back(word_lo);
            shadow_valid[word_lo[8:0]] = 1'b1;
            shadow_tag[word_lo[8:0]]   = word_lo[16:9];
        end
        lo_data = mem_word(word_lo);
        hi_data = mem_word(word_hi);
        if (addr[0]) begin
            exp_instr = {hi_data[15:0], lo_data[31:16]};
        end else begin
            exp_instr = lo_data;
        end

        @(posedge clk_i);
        #drive_delay;
        req_q.delete();
        fetch_addr_i = addr;
        @(negedge clk_i);
        first_stall = fetch_rsp_o.stall;
        while (fetch_rsp_o.stall) @(negedge clk_i);

        if (fetch_rsp_o.instr !== exp_instr) begin
            $display("[FAIL] %s: instr expected %h, actual %h", name, exp_instr,
                     fetch_rsp_o.instr);
            errs++;
        end
        if (first_stall != (exp_req.size() != 0)) begin
            $display("[FAIL] %s: first cycle stall expected %0d, actual %0d", name,
                     exp_req.size() != 0, first_stall);
            errs++;
        end
        if (req_q.size() != exp_req.size()) begin
            $display("[FAIL] %s: request count expected %0d, actual %0d", name,
                     exp_req.size(), req_q.size());
            errs++;
        end else begin
            foreach (req_q[i]) begin
                if (req_q[i] !== exp_req[i]) begin
                    $display("[FAIL] %s: request %0d address expected %h, actual %h", name,
                             i, exp_req[i], req_q[i]);
                    errs++;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        error_cnt += errs;
        if (errs == 0) begin
            $display("[PASS] %s", name);
        end else begin
            tests_failed++;
            $display("[DONE] %s ended with %0d failing checks", name, errs);
        end
    endtask

    // ##################################################
    // directed tests
    // ##################################################

    task automatic test_reset_first_fetch();
        int errs;
        errs = 0;
        if (reset_req_seen) begin
            $display("ERROR: reset_first_fetch saw a memory request while reset was high.");
            errs++;
        end
        fetch_check("reset_first_fetch", make_addr(8'd0, 9'd2, 1'b0), errs);
        report_test("reset_first_fetch", errs);
    endtask

    task automatic test_aligned_hit();
        int errs;
        errs = 0;
        fetch_check("aligned_hit miss", make_addr(8'd0, 9'd10, 1'b0), errs);
        fetch_check("aligned_hit repeat", make_addr(8'd0, 9'd10, 1'b0), errs);
        report_test("aligned_hit", errs);
    endtask

    task automatic test_misaligned_split();
        int errs;
        errs = 0;
        fetch_check("misaligned_split", make_addr(8'd3, 9'd100, 1'b1), errs);
        report_test("misaligned_split", errs);
    endtask

    task automatic test_tag_conflict();
        int errs;
        errs = 0;
        fetch_check("tag_conflict first", make_addr(8'd1, 9'd40, 1'b0), errs);
        fetch_check("tag_conflict evict", make_addr(8'd2, 9'd40, 1'b0), errs);
        fetch_check("tag_conflict refetch", make_addr(8'd1, 9'd40, 1'b0), errs);
        report_test("tag_conflict", errs);
    endtask

    task automatic test_random_run();
        int         errs;
        logic [7:0] tag;
        logic [8:0] idx;
        logic       half;
        errs = 0;
        for (int n = 0; n < 200; n++) begin
            tag  = 8'($unsigned($random(seed)) % 4);
            idx  = 9'($unsigned($random(seed)) % 32);
            half = 1'($unsigned($random(seed)) % 2);
            fetch_check($sformatf("random_run[%0d]", n), make_addr(tag, idx, half), errs);
        end
        report_test("random_run", errs);
    endtask

    initial begin : main
        rst_i        = 1'b1;
        fetch_addr_i = '0;
        repeat (4) @(posedge clk_i);
        #drive_delay;
        rst_i = 1'b0;
        test_reset_first_fetch();
        test_aligned_hit();
        test_misaligned_split();
        test_tag_conflict();
        test_random_run();
        $display("tests run %0d, tests failed %0d, failing checks %0d", tests_run,
                 tests_failed, error_cnt);
        if (error_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
verilog/icache_pkg.sv
verilog/icache_data_ram.sv
verilog/icache_tag_store.sv
verilog/icache_fetch_ctrl.sv
verilog/icache_top.sv
testbench/icache_chk.sv
testbench/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module icache_tb -f compile.f -Mdir obj_dir -o icache_sim

status=0
./obj_dir/icache_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim: the testbench reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "run_sim: the simulator exited with status $status"
    exit 1
fi
echo "run_sim: no failure found in sim.log"
